//--- source/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define RESET_PC    32'h0000_0000
`define NOP_INSTR   32'h0000_0013   // addi x0, x0, 0

// opcodes
`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011

// funct3 / funct7
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_SRL      3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_WORD     3'b010
`define F7_SUB      7'b0100000

// alu operations
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLT     4'd5
`define ALU_SLL     4'd6
`define ALU_SRL     4'd7

// writeback sources
`define WB_ALU      2'd0
`define WB_MEM      2'd1
`define WB_IMM      2'd2

`endif

//--- source/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  wb_src_t;

    //////////////////////////////////////////////////
    // pipeline registers
    //////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     op_a;        // rs1 after forwarding
        word_t     op_b;        // rs2 or immediate
        word_t     store_data;
        word_t     imm;
        alu_op_t   alu_op;
        logic      is_branch;
        logic      branch_ne;
        logic      mem_rd;
        logic      mem_wr;
        wb_src_t   wb_src;
        reg_addr_t rd;
        logic      rd_wr;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     alu_result;
        word_t     store_data;
        word_t     imm;
        logic      mem_rd;
        logic      mem_wr;
        wb_src_t   wb_src;
        reg_addr_t rd;
        logic      rd_wr;
    } ex_mem_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rd_wr;
        word_t     data;
    } mem_wb_t;

    // result fed back to decode
    typedef struct packed {
        reg_addr_t rd;
        logic      rd_wr;
        word_t     data;
    } fwd_t;

endpackage

//--- source/fetch_stage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module fetch_stage (
    input  logic            clk,
    input  logic            arst_n_i,
    input  cpu_pkg::word_t  instruction_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  cpu_pkg::word_t  redirect_pc_i,
    output cpu_pkg::word_t  pc_o,
    output cpu_pkg::if_id_t if_id_o
);

    cpu_pkg::word_t  pc_q;
    cpu_pkg::if_id_t if_id_q;

    // static not-taken, so only a resolved branch moves the pc off pc+4
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    //////////////////////////////////////////////////
    // if/id register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_q <= '{valid: 1'b0, pc: `RESET_PC, instr: `NOP_INSTR};
        end else if (redirect_i) begin
            if_id_q <= '{valid: 1'b0, pc: pc_q, instr: `NOP_INSTR};  // wrong-path fetch
        end else if (!stall_i) begin
            if_id_q <= '{valid: 1'b1, pc: pc_q, instr: instruction_i};
        end
    end

    assign pc_o    = pc_q;
    assign if_id_o = if_id_q;

endmodule

//--- source/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module decode_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  cpu_pkg::if_id_t    if_id_i,
    input  cpu_pkg::word_t     rs1_data_i,
    input  cpu_pkg::word_t     rs2_data_i,
    output cpu_pkg::reg_addr_t rs1_addr_o,
    output cpu_pkg::reg_addr_t rs2_addr_o,
    input  cpu_pkg::fwd_t      ex_fwd_i,
    input  cpu_pkg::fwd_t      mem_fwd_i,
    input  cpu_pkg::mem_wb_t   wb_i,
    input  logic               redirect_i,
    output logic               stall_o,
    output cpu_pkg::id_ex_t    id_ex_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::word_t     imm_i;
    cpu_pkg::word_t     imm_s;
    cpu_pkg::word_t     imm_b;
    cpu_pkg::word_t     imm_u;
    cpu_pkg::word_t     rs1_val;
    cpu_pkg::word_t     rs2_val;
    logic               uses_rs2;
    cpu_pkg::id_ex_t    id_ex_d;
    cpu_pkg::id_ex_t    id_ex_q;

    // newest producer wins, x0 never forwards
    function automatic cpu_pkg::word_t fwd_sel(
        input cpu_pkg::reg_addr_t addr,
        input cpu_pkg::word_t     rf_val,
        input cpu_pkg::fwd_t      ex_fwd,
        input cpu_pkg::fwd_t      mem_fwd,
        input cpu_pkg::mem_wb_t   wb
    );
        cpu_pkg::word_t val;
        val = rf_val;
        if (addr != '0) begin
            if (ex_fwd.rd_wr && ex_fwd.rd == addr) begin
                val = ex_fwd.data;
            end else if (mem_fwd.rd_wr && mem_fwd.rd == addr) begin
                val = mem_fwd.data;
            end else if (wb.rd_wr && wb.rd == addr) begin
                val = wb.data;
            end
        end
        return val;
    endfunction

    assign opcode = if_id_i.instr[6:0];
    assign rd     = if_id_i.instr[11:7];
    assign funct3 = if_id_i.instr[14:12];
    assign rs1    = if_id_i.instr[19:15];
    assign rs2    = if_id_i.instr[24:20];
    assign funct7 = if_id_i.instr[31:25];

    assign imm_i = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
    assign imm_s = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:25], if_id_i.instr[11:7]};
    assign imm_b = {{19{if_id_i.instr[31]}}, if_id_i.instr[31], if_id_i.instr[7],
                    if_id_i.instr[30:25], if_id_i.instr[11:8], 1'b0};
    assign imm_u = {if_id_i.instr[31:12], 12'b0};

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    always_comb begin
        rs1_val = fwd_sel(rs1, rs1_data_i, ex_fwd_i, mem_fwd_i, wb_i);
        rs2_val = fwd_sel(rs2, rs2_data_i, ex_fwd_i, mem_fwd_i, wb_i);
    end

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.valid      = if_id_i.valid;
        id_ex_d.pc         = if_id_i.pc;
        id_ex_d.op_a       = rs1_val;
        id_ex_d.op_b       = imm_i;
        id_ex_d.store_data = rs2_val;
        id_ex_d.imm        = imm_i;
        id_ex_d.alu_op     = `ALU_ADD;
        id_ex_d.wb_src     = `WB_ALU;
        id_ex_d.rd         = rd;
        uses_rs2           = 1'b0;
        case (opcode)
            `OPC_OP, `OPC_OPIMM: begin
                uses_rs2      = (opcode == `OPC_OP);
                id_ex_d.op_b  = uses_rs2 ? rs2_val : imm_i;
                id_ex_d.rd_wr = 1'b1;
                case (funct3)
                    `F3_ADD: id_ex_d.alu_op = (uses_rs2 && funct7 == `F7_SUB) ? `ALU_SUB
                                                                               : `ALU_ADD;
                    `F3_SLT: id_ex_d.alu_op = `ALU_SLT;
                    `F3_XOR: id_ex_d.alu_op = `ALU_XOR;
                    `F3_OR:  id_ex_d.alu_op = `ALU_OR;
                    `F3_AND: id_ex_d.alu_op = `ALU_AND;
                    `F3_SLL: begin
                        id_ex_d.alu_op = `ALU_SLL;
                        id_ex_d.rd_wr  = uses_rs2;  // no immediate shifts
                    end
                    `F3_SRL: begin
                        id_ex_d.alu_op = `ALU_SRL;
                        id_ex_d.rd_wr  = uses_rs2;
                    end
                    default: id_ex_d.rd_wr = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                id_ex_d.imm    = imm_u;
                id_ex_d.wb_src = `WB_IMM;
                id_ex_d.rd_wr  = 1'b1;
            end
            `OPC_LOAD: begin
                id_ex_d.mem_rd = (funct3 == `F3_WORD);
                id_ex_d.rd_wr  = (funct3 == `F3_WORD);
                id_ex_d.wb_src = `WB_MEM;
            end
            `OPC_STORE: begin
                uses_rs2       = 1'b1;
                id_ex_d.op_b   = imm_s;
                id_ex_d.imm    = imm_s;
                id_ex_d.mem_wr = (funct3 == `F3_WORD);
            end
            `OPC_BRANCH: begin
                uses_rs2          = 1'b1;
                id_ex_d.op_b      = rs2_val;
                id_ex_d.imm       = imm_b;
                id_ex_d.is_branch = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
                id_ex_d.branch_ne = (funct3 == `F3_BNE);
            end
            default: ;  // unknown opcode runs as a nop
        endcase
    end

    // load in ex, its data is only on the bus one cycle later
    assign stall_o = if_id_i.valid && id_ex_q.valid && id_ex_q.mem_rd && id_ex_q.rd != '0 &&
                     (id_ex_q.rd == rs1 || (uses_rs2 && id_ex_q.rd == rs2));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else if (redirect_i || stall_o) begin
            id_ex_q <= '0;  // bubble
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic               clk,
    input  logic               arst_n_i,
    input  cpu_pkg::reg_addr_t rs1_addr_i,
    input  cpu_pkg::reg_addr_t rs2_addr_i,
    output cpu_pkg::word_t     rs1_data_o,
    output cpu_pkg::word_t     rs2_data_o,
    input  cpu_pkg::mem_wb_t   wb_i
);

    cpu_pkg::word_t regs [1:31];   // x0 has no storage
    logic           wr_en;

    assign wr_en = wb_i.rd_wr && wb_i.rd != '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through so wb and decode can share a cycle
    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_addr_i != '0) begin
            rs1_data_o = (wr_en && wb_i.rd == rs1_addr_i) ? wb_i.data : regs[rs1_addr_i];
        end
        if (rs2_addr_i != '0) begin
            rs2_data_o = (wr_en && wb_i.rd == rs2_addr_i) ? wb_i.data : regs[rs2_addr_i];
        end
    end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module execute_stage (
    input  logic             clk,
    input  logic             arst_n_i,
    input  cpu_pkg::id_ex_t  id_ex_i,
    output logic             redirect_o,
    output cpu_pkg::word_t   redirect_pc_o,
    output cpu_pkg::fwd_t    ex_fwd_o,
    output cpu_pkg::ex_mem_t ex_mem_o
);

    cpu_pkg::word_t   alu_result;
    logic             operands_eq;
    cpu_pkg::ex_mem_t ex_mem_q;

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////

    always_comb begin
        case (id_ex_i.alu_op)
            `ALU_SUB: alu_result = id_ex_i.op_a - id_ex_i.op_b;
            `ALU_AND: alu_result = id_ex_i.op_a & id_ex_i.op_b;
            `ALU_OR:  alu_result = id_ex_i.op_a | id_ex_i.op_b;
            `ALU_XOR: alu_result = id_ex_i.op_a ^ id_ex_i.op_b;
            `ALU_SLT: alu_result = {31'b0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            `ALU_SLL: alu_result = id_ex_i.op_a << id_ex_i.op_b[4:0];
            `ALU_SRL: alu_result = id_ex_i.op_a >> id_ex_i.op_b[4:0];
            default:  alu_result = id_ex_i.op_a + id_ex_i.op_b;   // add, address calc
        endcase
    end

    // predicted not-taken, any taken branch is a redirect
    assign operands_eq   = (id_ex_i.op_a == id_ex_i.op_b);
    assign redirect_o    = id_ex_i.valid && id_ex_i.is_branch &&
                           (operands_eq != id_ex_i.branch_ne);
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    // distance-1 forwarding, loads are caught by the stall in decode
    assign ex_fwd_o.rd    = id_ex_i.rd;
    assign ex_fwd_o.rd_wr = id_ex_i.valid && id_ex_i.rd_wr;
    assign ex_fwd_o.data  = (id_ex_i.wb_src == `WB_IMM) ? id_ex_i.imm : alu_result;

    //////////////////////////////////////////////////
    // ex/mem register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.alu_result <= alu_result;
            ex_mem_q.store_data <= id_ex_i.store_data;
            ex_mem_q.imm        <= id_ex_i.imm;
            ex_mem_q.mem_rd     <= id_ex_i.mem_rd;
            ex_mem_q.mem_wr     <= id_ex_i.mem_wr;
            ex_mem_q.wb_src     <= id_ex_i.wb_src;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.rd_wr      <= id_ex_i.rd_wr;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

//--- source/mem_wb_stage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module mem_wb_stage (
    input  logic             clk,
    input  logic             arst_n_i,
    input  cpu_pkg::ex_mem_t ex_mem_i,
    input  cpu_pkg::word_t   mem_rd_data_i,
    output cpu_pkg::word_t   mem_addr_o,
    output cpu_pkg::word_t   mem_wr_data_o,
    output logic             mem_wr_o,
    output cpu_pkg::fwd_t    mem_fwd_o,
    output cpu_pkg::mem_wb_t mem_wb_o
);

    cpu_pkg::word_t   wb_data;
    logic             wr_valid;
    cpu_pkg::mem_wb_t mem_wb_q;

    // data bus, read data comes back in the same cycle
    assign mem_addr_o    = ex_mem_i.alu_result;
    assign mem_wr_data_o = ex_mem_i.store_data;
    assign mem_wr_o      = ex_mem_i.valid && ex_mem_i.mem_wr;

    always_comb begin
        if (ex_mem_i.mem_rd) begin
            wb_data = mem_rd_data_i;
        end else if (ex_mem_i.wb_src == `WB_IMM) begin
            wb_data = ex_mem_i.imm;   // lui
        end else begin
            wb_data = ex_mem_i.alu_result;
        end
    end

    assign wr_valid = ex_mem_i.valid && ex_mem_i.rd_wr;

    assign mem_fwd_o.rd    = ex_mem_i.rd;
    assign mem_fwd_o.rd_wr = wr_valid;
    assign mem_fwd_o.data  = wb_data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q <= '{rd: ex_mem_i.rd, rd_wr: wr_valid, data: wb_data};
        end
    end

    assign mem_wb_o = mem_wb_q;

endmodule

//--- source/cpu.sv
`timescale 1ns/100ps

module cpu (
    input  logic           clk,
    input  logic           arst_n_i,

    input  cpu_pkg::word_t instruction_i,
    output cpu_pkg::word_t rom_addr_o,

    input  cpu_pkg::word_t mem_rd_data_i,
    output cpu_pkg::word_t mem_addr_o,
    output cpu_pkg::word_t mem_wr_data_o,
    output logic           mem_wr_o
);

    cpu_pkg::if_id_t    if_id;
    cpu_pkg::id_ex_t    id_ex;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::mem_wb_t   mem_wb;

    cpu_pkg::fwd_t      ex_fwd;
    cpu_pkg::fwd_t      mem_fwd;

    cpu_pkg::reg_addr_t rs1_addr;
    cpu_pkg::reg_addr_t rs2_addr;
    cpu_pkg::word_t     rs1_data;
    cpu_pkg::word_t     rs2_data;

    logic               stall;
    logic               redirect;
    cpu_pkg::word_t     redirect_pc;

    fetch_stage fetch_stage_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instruction_i (instruction_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .pc_o          (rom_addr_o),
        .if_id_o       (if_id)
    );

    decode_stage decode_stage_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .if_id_i    (if_id),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .ex_fwd_i   (ex_fwd),
        .mem_fwd_i  (mem_fwd),
        .wb_i       (mem_wb),
        .redirect_i (redirect),
        .stall_o    (stall),
        .id_ex_o    (id_ex)
    );

    register_file register_file_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (mem_wb)
    );

    execute_stage execute_stage_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .id_ex_i       (id_ex),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_fwd_o      (ex_fwd),
        .ex_mem_o      (ex_mem)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .ex_mem_i      (ex_mem),
        .mem_rd_data_i (mem_rd_data_i),
        .mem_addr_o    (mem_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .mem_wr_o      (mem_wr_o),
        .mem_fwd_o     (mem_fwd),
        .mem_wb_o      (mem_wb)
    );

endmodule

//--- tests/cpu_checker.sv
`timescale 1ns/100ps

module cpu_checker (
    input logic           clk_i,
    input logic           arst_n_i,
    input logic           mem_wr_i,
    input cpu_pkg::word_t rom_addr_i,
    input logic           stall_i,
    input logic           redirect_i
);

    int fails = 0;

    wr_known: assert property (@(posedge clk_i) disable iff (!arst_n_i) !$isunknown(mem_wr_i))
        else begin
            fails++;
            $error("mem_wr_o is unknown");
        end

    pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i) rom_addr_i[1:0] == 2'b00)
        else begin
            fails++;
            $error("rom_addr_o is not word aligned");
        end

    // a stall without a redirect freezes the fetch address
    pc_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                              stall_i && !redirect_i |=> $stable(rom_addr_i))
        else begin
            fails++;
            $error("rom_addr_o moved during a stall");
        end

endmodule

//--- tests/cpu_monitor.sv
`timescale 1ns/100ps

module cpu_monitor (
    input logic           clk_i,
    input logic           arst_n_i,
    input cpu_pkg::word_t mem_addr_i,
    input cpu_pkg::word_t mem_wr_data_i,
    input logic           mem_wr_i
);

    cpu_pkg::word_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    int             errors = 0;

    function automatic void expect_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endfunction

    task automatic finish_check(input string name);
        if (exp_addr.size() != 0) begin
            $display("%s: %0d expected stores never appeared", name, exp_addr.size());
            errors++;
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    // the store strobe is stable around the falling edge
    always @(negedge clk_i) begin
        cpu_pkg::word_t a;
        cpu_pkg::word_t d;
        if (arst_n_i && mem_wr_i) begin
            if (exp_addr.size() == 0) begin
                $display("extra store at time %0t to address %h", $time, mem_addr_i);
                errors++;
            end else begin
                a = exp_addr.pop_front();
                d = exp_data.pop_front();
                if (mem_addr_i !== a) begin
                    $display("FAILED time=%0t mem_addr_o expected %h got %h", $time, a, mem_addr_i);
                    errors++;
                end
                if (mem_wr_data_i !== d) begin
                    $display("FAILED time=%0t mem_wr_data_o expected %h got %h",
                             $time, d, mem_wr_data_i);
                    errors++;
                end
            end
        end
    end

endmodule

//--- tests/tb_cpu.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module tb_clock (
    output logic clk_o
);
    initial clk_o = 1'b0;
    always #10 clk_o = ~clk_o;   // 20 ns
endmodule

module tb_cpu;

    logic           clk;
    logic           arst_n;
    cpu_pkg::word_t instruction;
    cpu_pkg::word_t rom_addr;
    cpu_pkg::word_t mem_rd_data;
    cpu_pkg::word_t mem_addr;
    cpu_pkg::word_t mem_wr_data;
    logic           mem_wr;

    cpu_pkg::word_t rom [0:511];
    cpu_pkg::word_t dmem [0:63];
    cpu_pkg::word_t ref_mem [0:63];
    int             n_words;
    int             errors = 0;
    int             cycles = 0;
    int             limit = 0;
    logic           running = 1'b0;
    cpu_pkg::word_t halt_pc;

    tb_clock clock_gen (.clk_o(clk));

    cpu dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .instruction_i (instruction),
        .rom_addr_o    (rom_addr),
        .mem_rd_data_i (mem_rd_data),
        .mem_addr_o    (mem_addr),
        .mem_wr_data_o (mem_wr_data),
        .mem_wr_o      (mem_wr)
    );

    cpu_monitor mon (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .mem_addr_i    (mem_addr),
        .mem_wr_data_i (mem_wr_data),
        .mem_wr_i      (mem_wr)
    );

    bind cpu cpu_checker checker_inst (
        .clk_i (clk), .arst_n_i (arst_n_i), .mem_wr_i (mem_wr_o),
        .rom_addr_i (rom_addr_o), .stall_i (stall), .redirect_i (redirect)
    );

    //////////////////////////////////////////////////
    // bus models
    //////////////////////////////////////////////////

    // buses are combinational, values settle half a cycle before the sampling edge
    always @(negedge clk) begin
        if (arst_n && mem_wr) dmem[mem_addr[7:2]] = mem_wr_data;
        instruction <= rom[rom_addr[10:2]];
        mem_rd_data <= dmem[mem_addr[7:2]];
    end

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > limit) begin
                $display("program never halted within %0d cycles", limit);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    //////////////////////////////////////////////////
    // instruction encoding
    //////////////////////////////////////////////////

    function automatic cpu_pkg::word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
    endfunction

    function automatic cpu_pkg::word_t i_type(int opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic cpu_pkg::word_t sw_ins(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], `F3_WORD, imm[4:0], `OPC_STORE};
    endfunction

    function automatic cpu_pkg::word_t br_ins(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], `OPC_BRANCH};
    endfunction

    task automatic emit(input cpu_pkg::word_t w);
        rom[n_words] = w;
        n_words++;
    endtask

    task automatic emit_halt();
        halt_pc = n_words * 4;
        emit(br_ins(`F3_BEQ, 0, 0, 0));
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // ISA-level interpreter, one instruction at a time with no pipeline
    function automatic int iss_run();
        cpu_pkg::word_t x [0:31];
        cpu_pkg::word_t w, a, b, res, pc, imm_i, imm_s, imm_b;
        int n;
        logic wr;
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < 64; i++) ref_mem[i] = dmem[i];
        pc = 0;
        n = 0;
        while (pc != halt_pc && n < 10000) begin
            w = rom[pc[10:2]];
            a = x[w[19:15]];
            b = x[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            wr = 1'b0;
            res = '0;
            pc = pc + 4;
            if (w[6:0] == `OPC_OP || w[6:0] == `OPC_OPIMM) begin
                if (w[6:0] == `OPC_OPIMM) b = imm_i;
                wr = 1'b1;
                case (w[14:12])
                    `F3_ADD: res = (w[6:0] == `OPC_OP && w[31:25] == `F7_SUB) ? a - b : a + b;
                    `F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `F3_XOR: res = a ^ b;
                    `F3_OR:  res = a | b;
                    `F3_AND: res = a & b;
                    `F3_SLL: res = a << b[4:0];
                    default: res = a >> b[4:0];
                endcase
                if (w[6:0] == `OPC_OPIMM && (w[14:12] == `F3_SLL || w[14:12] == `F3_SRL))
                    wr = 1'b0;   // immediate shifts are not in the subset
            end else if (w[6:0] == `OPC_LUI) begin
                wr = 1'b1;
                res = {w[31:12], 12'b0};
            end else if (w[6:0] == `OPC_LOAD && w[14:12] == `F3_WORD) begin
                res = a + imm_i;
                res = ref_mem[res[7:2]];
                wr = 1'b1;
            end else if (w[6:0] == `OPC_STORE && w[14:12] == `F3_WORD) begin
                res = a + imm_s;
                ref_mem[res[7:2]] = b;
                mon.expect_store(res, b);
            end else if (w[6:0] == `OPC_BRANCH) begin
                if ((w[14:12] == `F3_BEQ && a == b) || (w[14:12] == `F3_BNE && a != b))
                    pc = pc - 4 + imm_b;
            end
            if (wr) x[w[11:7]] = res;
            x[0] = '0;
            n++;
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // program runs
    //////////////////////////////////////////////////

    task automatic load_start();
        @(posedge clk);
        arst_n <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < 512; i++) rom[i] = `NOP_INSTR;
        for (int i = 0; i < 64; i++) dmem[i] = {8'hd0, 8'(i * 7), 16'(i * i) ^ 16'h5a5a};
        n_words = 0;
    endtask

    task automatic run_program(input string name);
        int n;
        n = iss_run();
        limit = 8 * n + 100;
        cycles = 0;
        repeat (9) @(posedge clk);
        // fetch starts from the reset vector with no store pending
        if (rom_addr !== `RESET_PC) begin
            $display("FAILED time=%0t rom_addr_o expected %h got %h",
                     $time, `RESET_PC, rom_addr);
            errors++;
        end
        if (mem_wr !== 1'b0) begin
            $display("FAILED time=%0t mem_wr_o expected 0 got %b", $time, mem_wr);
            errors++;
        end
        arst_n <= 1'b1;
        running = 1'b1;
        do @(negedge clk); while (!(dut.redirect && dut.id_ex.pc == halt_pc));
        repeat (4) @(negedge clk);
        running = 1'b0;
        mon.finish_check(name);
        for (int i = 0; i < 64; i++) begin
            if (dmem[i] !== ref_mem[i]) begin
                $display("FAILED time=%0t dmem[%0d] expected %h got %h",
                         $time, i, ref_mem[i], dmem[i]);
                errors++;
            end
        end
    endtask

    initial begin
        int sel, rd, rs1, rs2, off;
        arst_n = 1'b0;
        instruction = `NOP_INSTR;
        mem_rd_data = '0;
        void'($urandom(32'hc393));

        // alu, forwarding, x0, lui, load-use
        load_start();
        emit(i_type(`OPC_OPIMM, `F3_ADD, 1, 0, -5));
        emit(i_type(`OPC_OPIMM, `F3_ADD, 2, 0, 3));
        emit(r_type(`F7_SUB, `F3_ADD, 3, 1, 2));
        emit(r_type(0, `F3_ADD, 4, 3, 1));
        emit(r_type(0, `F3_SLT, 5, 1, 2));
        emit(r_type(0, `F3_SLT, 6, 2, 1));
        emit(i_type(`OPC_OPIMM, `F3_SLT, 7, 1, -4));
        emit(r_type(0, `F3_SLL, 8, 2, 2));
        emit(r_type(0, `F3_SRL, 9, 1, 2));
        emit(r_type(0, `F3_XOR, 10, 1, 2));
        emit(r_type(0, `F3_OR, 11, 1, 2));
        emit(r_type(0, `F3_AND, 12, 1, 2));
        emit(i_type(`OPC_OPIMM, `F3_AND, 13, 1, 'h0f0));
        emit(i_type(`OPC_OPIMM, `F3_OR, 14, 2, 'h700));
        emit(i_type(`OPC_OPIMM, `F3_XOR, 15, 1, -1));
        for (int r = 3; r <= 15; r++) emit(sw_ins(r, 0, 'h80 + 4 * (r - 3)));
        emit(i_type(`OPC_OPIMM, `F3_ADD, 0, 0, 7));
        emit(r_type(0, `F3_ADD, 0, 1, 2));
        emit(sw_ins(0, 0, 'hb4));
        emit({20'habcde, 5'd16, `OPC_LUI});
        emit(sw_ins(16, 0, 'hb8));
        emit(i_type(`OPC_OPIMM, `F3_ADD, 17, 16, 'h123));
        emit(sw_ins(17, 0, 'hbc));
        emit(i_type(`OPC_LOAD, `F3_WORD, 18, 0, 'h80));
        emit(r_type(0, `F3_ADD, 19, 18, 18));
        emit(sw_ins(19, 0, 'h84));
        emit(i_type(`OPC_LOAD, `F3_WORD, 20, 0, 'hb8));
        emit(sw_ins(20, 0, 'h88));
        emit(i_type(`OPC_LOAD, `F3_WORD, 21, 0, 'h84));
        emit(r_type(`F7_SUB, `F3_ADD, 22, 21, 18));
        emit(sw_ins(22, 0, 'h8c));
        emit_halt();
        run_program("directed");

        // branches, loop and shadow slots
        load_start();
        emit(i_type(`OPC_OPIMM, `F3_ADD, 1, 0, 0));
        emit(i_type(`OPC_OPIMM, `F3_ADD, 2, 0, 5));
        emit(i_type(`OPC_OPIMM, `F3_ADD, 1, 1, 1));
        emit(sw_ins(1, 0, 'h90));
        emit(br_ins(`F3_BNE, 1, 2, -8));
        emit(br_ins(`F3_BEQ, 0, 0, 12));
        emit(sw_ins(1, 0, 'h94));
        emit(sw_ins(1, 0, 'h98));
        emit(sw_ins(2, 0, 'h9c));
        emit(br_ins(`F3_BEQ, 1, 0, 8));
        emit(sw_ins(2, 0, 'ha0));
        emit(br_ins(`F3_BNE, 1, 1, 8));
        emit(sw_ins(1, 0, 'ha4));
        emit(br_ins(`F3_BEQ, 1, 2, 12));
        emit(sw_ins(0, 0, 'ha8));
        emit(sw_ins(0, 0, 'hac));
        emit_halt();
        run_program("branches");

        // random alu, load and store mix
        load_start();
        for (int k = 0; k < 200; k++) begin
            sel = $urandom_range(0, 9);
            rd  = $urandom_range(1, 7);
            rs1 = $urandom_range(1, 7);
            rs2 = $urandom_range(1, 7);
            off = 'h80 + 4 * $urandom_range(0, 15);
            case (sel)
                0, 1, 2, 3: begin
                    case ($urandom_range(0, 7))
                        0: emit(r_type(0, `F3_ADD, rd, rs1, rs2));
                        1: emit(r_type(`F7_SUB, `F3_ADD, rd, rs1, rs2));
                        2: emit(r_type(0, `F3_SLL, rd, rs1, rs2));
                        3: emit(r_type(0, `F3_SLT, rd, rs1, rs2));
                        4: emit(r_type(0, `F3_XOR, rd, rs1, rs2));
                        5: emit(r_type(0, `F3_SRL, rd, rs1, rs2));
                        6: emit(r_type(0, `F3_OR, rd, rs1, rs2));
                        default: emit(r_type(0, `F3_AND, rd, rs1, rs2));
                    endcase
                end
                4: emit(i_type(`OPC_OPIMM, `F3_ADD, rd, rs1, $urandom));
                5: emit(i_type(`OPC_OPIMM, `F3_SLT, rd, rs1, $urandom));
                6, 7: emit(i_type(`OPC_LOAD, `F3_WORD, rd, 0, off));
                default: emit(sw_ins(rs2, 0, off));
            endcase
        end
        emit_halt();
        run_program("random");

        errors = errors + mon.errors + dut.checker_inst.fails;
        $display("errors: %0d (stores %0d, assertions %0d)",
                 errors, mon.errors, dut.checker_inst.fails);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/cpu.sv
tests/cpu_checker.sv
tests/cpu_monitor.sv
tests/tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f vlog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cpu +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
